//--- hdl/radio_pkg.sv
/*
 * Shared register map, readback map and response format of the radio datapath.
 * Response words are one 64-bit beat: code in the top nibble, time in the low 48 bits.
 * Bits 59 to 48 of a response are always zero.
 */
`default_nettype none

package radio_pkg;

  // Settings bus addresses
  typedef enum logic [7:0] {
    SR_LOOPBACK   = 8'd128,
    SR_TEST       = 8'd129,
    SR_CODEC_IDLE = 8'd130,
    SR_RX_CMD     = 8'd152,
    SR_RX_MAXLEN  = 8'd155,
    SR_RX_HALT    = 8'd156
  } sr_addr_e;

  // Readback addresses
  typedef enum logic [7:0] {
    RB_VITA_TIME    = 8'd0,
    RB_VITA_LASTPPS = 8'd1,
    RB_TEST         = 8'd2,
    RB_TXRX         = 8'd3,
    RB_RADIO_NUM    = 8'd4
  } rb_addr_e;

  // Response codes, placed in the top nibble of a response word
  typedef enum logic [3:0] {
    RESP_TX_ACK      = 4'h1,
    RESP_TX_UNDERRUN = 4'h2,
    RESP_RX_OVERFLOW = 4'h8
  } resp_code_e;

  typedef enum logic {TX_IDLE, TX_RUN} tx_state_e;
  typedef enum logic {RX_IDLE, RX_RUN} rx_state_e;

  // Response word field positions
  localparam int RESP_CODE_LSB = 60;
  localparam int RESP_CODE_W   = 4;
  localparam int RESP_TIME_W   = 48;

  // Packet length used while the MAXLEN register holds zero
  localparam logic [15:0] RX_MAXLEN_DEFAULT = 16'd4096;

  // Builds one response word stamped with the given time
  function automatic logic [63:0] resp_word(resp_code_e code, logic [63:0] t);
    logic [63:0] w;
    w = '0;
    w[RESP_CODE_LSB +: RESP_CODE_W] = code;
    w[RESP_TIME_W-1:0] = t[RESP_TIME_W-1:0];
    return w;
  endfunction

endpackage

`default_nettype wire

//--- hdl/setting_reg.sv
/*
 * One settings-bus register. Loads the low WIDTH bits of the bus data in the
 * cycle after a strobe whose address equals MY_ADDR. WIDTH is 1 to 32.
 * Resets to zero. o_changed is high while the new value first shows.
 */
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
  parameter logic [7:0] MY_ADDR = 8'd0,
  parameter int         WIDTH   = 32
) (
  input  wire              i_clk,
  input  wire              i_reset,
  input  wire              i_set_stb,
  input  wire  [7:0]       i_set_addr,
  input  wire  [31:0]      i_set_data,
  output logic [WIDTH-1:0] o_out,
  output logic             o_changed
);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_out     <= '0;
      o_changed <= 1'b0;
    end else begin
      // Write pulse follows every matching strobe, even with equal data
      o_changed <= i_set_stb && (i_set_addr == MY_ADDR);
      if (i_set_stb && (i_set_addr == MY_ADDR)) begin
        o_out <= i_set_data[WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/radio_tx_control.sv
/*
 * Transmit burst player. One stream beat is taken per converter strobe.
 * A strobe with no beat ends a burst: after a tlast beat this gives an ACK,
 * otherwise an underrun. Between bursts the idle register is driven.
 * One response word is held; a newer event overwrites an untaken one.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_tx_control
  import radio_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire  [63:0] i_vita_time,
  input  wire  [31:0] i_tx_tdata,
  input  wire         i_tx_tlast,
  input  wire         i_tx_tvalid,
  output logic        o_tx_tready,
  input  wire         i_tx_stb,
  output logic [31:0] o_tx,
  output logic        o_tx_running,
  output logic [63:0] o_resp_tdata,
  output logic        o_resp_valid,
  input  wire         i_resp_taken
);

  tx_state_e   state;
  logic [31:0] idle_value;
  logic [31:0] sample;
  logic        last_seen;
  logic        tx_accept;
  logic        end_burst;
  resp_code_e  end_code;

  // Value driven to the converter between bursts
  setting_reg #(.MY_ADDR(SR_CODEC_IDLE), .WIDTH(32)) sr_codec_idle (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_out      (idle_value),
    .o_changed  ()
  );

  // The converter strobe paces the stream directly
  assign o_tx_tready = i_tx_stb;
  assign tx_accept   = i_tx_stb & i_tx_tvalid;
  // Starved strobe inside a burst
  assign end_burst   = i_tx_stb & ~i_tx_tvalid & (state == TX_RUN);
  // Clean end only when the burst already delivered its tlast beat
  assign end_code    = last_seen ? RESP_TX_ACK : RESP_TX_UNDERRUN;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state        <= TX_IDLE;
      last_seen    <= 1'b0;
      o_resp_valid <= 1'b0;
    end else begin
      if (tx_accept) begin
        // A beat after tlast simply opens the next burst
        state     <= TX_RUN;
        last_seen <= i_tx_tlast;
      end else if (end_burst) begin
        state     <= TX_IDLE;
        last_seen <= 1'b0;
      end
      // New event wins over a same-cycle take
      if (end_burst) begin
        o_resp_valid <= 1'b1;
      end else if (i_resp_taken) begin
        o_resp_valid <= 1'b0;
      end
    end
  end

  // Sample and response payload
  always_ff @(posedge i_clk) begin
    if (tx_accept) begin
      sample <= i_tx_tdata;
    end
    if (end_burst) begin
      o_resp_tdata <= resp_word(end_code, i_vita_time);
    end
  end

  assign o_tx_running = (state == TX_RUN);
  assign o_tx         = o_tx_running ? sample : idle_value;

endmodule

`default_nettype wire

//--- hdl/radio_rx_control.sv
/*
 * Receive command engine. A command write starts a finite or continuous run;
 * bit 31 selects continuous, bits 27:0 give the sample count.
 * Writing 1 to the halt register ends the run after the next sample.
 * A MAXLEN register of zero means the default packet length.
 * A strobe while the output beat is stuck drops the sample and stops the run.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_rx_control
  import radio_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire  [63:0] i_vita_time,
  input  wire  [31:0] i_sample,
  input  wire         i_strobe,
  output logic [31:0] o_rx_tdata,
  output logic        o_rx_tlast,
  output logic        o_rx_tvalid,
  input  wire         i_rx_tready,
  output logic        o_rx_running,
  output logic [63:0] o_resp_tdata,
  output logic        o_resp_valid,
  input  wire         i_resp_taken
);

  rx_state_e   state;
  logic [31:0] cmd;
  logic        cmd_changed;
  logic [15:0] maxlen_reg;
  logic [15:0] maxlen;
  logic        halt_bit;
  logic        halt_changed;
  logic        halt_req;
  logic        halt_pend;
  logic        continuous;
  logic [27:0] remaining;
  logic [15:0] pkt_cnt;
  logic        start;
  logic        load;
  logic        overflow;
  logic        final_sample;
  logic        pkt_end;

  setting_reg #(.MY_ADDR(SR_RX_CMD), .WIDTH(32)) sr_cmd (
    .i_clk(i_clk), .i_reset(i_reset), .i_set_stb(i_set_stb), .i_set_addr(i_set_addr),
    .i_set_data(i_set_data), .o_out(cmd), .o_changed(cmd_changed));

  setting_reg #(.MY_ADDR(SR_RX_MAXLEN), .WIDTH(16)) sr_maxlen (
    .i_clk(i_clk), .i_reset(i_reset), .i_set_stb(i_set_stb), .i_set_addr(i_set_addr),
    .i_set_data(i_set_data), .o_out(maxlen_reg), .o_changed());

  setting_reg #(.MY_ADDR(SR_RX_HALT), .WIDTH(1)) sr_halt (
    .i_clk(i_clk), .i_reset(i_reset), .i_set_stb(i_set_stb), .i_set_addr(i_set_addr),
    .i_set_data(i_set_data), .o_out(halt_bit), .o_changed(halt_changed));

  assign maxlen   = (maxlen_reg == 16'd0) ? RX_MAXLEN_DEFAULT : maxlen_reg;
  assign halt_req = halt_changed & halt_bit;
  // Zero-count finite commands are ignored
  assign start    = (state == RX_IDLE) & cmd_changed & (cmd[31] | (cmd[27:0] != 28'd0));
  // Output slot is free or drains this cycle
  assign load     = (state == RX_RUN) & i_strobe & ~(o_rx_tvalid & ~i_rx_tready);
  assign overflow = (state == RX_RUN) & i_strobe & o_rx_tvalid & ~i_rx_tready;
  // Last sample of the command, by count or by halt
  assign final_sample = (~continuous & (remaining == 28'd1)) | halt_pend | halt_req;
  assign pkt_end      = (pkt_cnt == maxlen - 16'd1);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state        <= RX_IDLE;
      continuous   <= 1'b0;
      remaining    <= '0;
      pkt_cnt      <= '0;
      halt_pend    <= 1'b0;
      o_rx_tvalid  <= 1'b0;
      o_resp_valid <= 1'b0;
    end else begin
      if (start) begin
        state      <= RX_RUN;
        continuous <= cmd[31];
        remaining  <= cmd[27:0];
        pkt_cnt    <= '0;
        halt_pend  <= 1'b0;
      end else if (overflow) begin
        state <= RX_IDLE;
      end else if (load) begin
        if (!continuous) begin
          remaining <= remaining - 28'd1;
        end
        pkt_cnt <= (final_sample || pkt_end) ? 16'd0 : pkt_cnt + 16'd1;
        if (final_sample) begin
          state <= RX_IDLE;
        end
      end else if (halt_req && (state == RX_RUN)) begin
        // Halt waits for the next sample
        halt_pend <= 1'b1;
      end
      // Beat valid until the host takes it
      if (load) begin
        o_rx_tvalid <= 1'b1;
      end else if (i_rx_tready) begin
        o_rx_tvalid <= 1'b0;
      end
      if (overflow) begin
        o_resp_valid <= 1'b1;
      end else if (i_resp_taken) begin
        o_resp_valid <= 1'b0;
      end
    end
  end

  // Beat and response payload
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_rx_tdata <= i_sample;
      o_rx_tlast <= final_sample | pkt_end;
    end
    if (overflow) begin
      o_resp_tdata <= resp_word(RESP_RX_OVERFLOW, i_vita_time);
    end
  end

  assign o_rx_running = (state == RX_RUN);

endmodule

`default_nettype wire

//--- hdl/radio_resp_mux.sv
/*
 * Merges the single-beat response words of the TX and RX controllers.
 * One output register; TX wins when both sources are pending.
 * The taken pulses are combinational and reach the source in the load cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_resp_mux (
  input  wire         i_clk,
  input  wire         i_reset,
  input  wire  [63:0] i_tx_tdata,
  input  wire         i_tx_valid,
  output logic        o_tx_taken,
  input  wire  [63:0] i_rx_tdata,
  input  wire         i_rx_valid,
  output logic        o_rx_taken,
  output logic [63:0] o_resp_tdata,
  output logic        o_resp_tvalid,
  input  wire         i_resp_ready
);

  logic can_load;

  // Register empty or its word leaves this cycle
  assign can_load   = ~o_resp_tvalid | i_resp_ready;
  assign o_tx_taken = can_load & i_tx_valid;
  // RX only when TX has nothing
  assign o_rx_taken = can_load & i_rx_valid & ~i_tx_valid;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_resp_tvalid <= 1'b0;
    end else if (can_load) begin
      o_resp_tvalid <= i_tx_valid | i_rx_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_tx_taken) begin
      o_resp_tdata <= i_tx_tdata;
    end else if (o_rx_taken) begin
      o_resp_tdata <= i_rx_tdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/radio_datapath_core.sv
/*
 * Clock-rate datapath of one radio channel with 32-bit samples.
 * Readback is combinational; unknown addresses return zero with no strobe.
 * Loopback feeds TX output and TX strobe into the RX path, so RX captures
 * the TX sample that was on the converter at each strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_datapath_core
  import radio_pkg::*;
#(
  parameter logic [31:0] RADIO_NUM = 32'd0
) (
  input  wire         i_clk,
  input  wire         i_reset,
  // Converter side
  input  wire  [31:0] i_rx,
  input  wire         i_rx_stb,
  output logic        o_rx_running,
  output logic [31:0] o_tx,
  input  wire         i_tx_stb,
  output logic        o_tx_running,
  // Time
  input  wire  [63:0] i_vita_time,
  input  wire  [63:0] i_vita_time_lastpps,
  // Settings bus and readback
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire  [7:0]  i_rb_addr,
  input  wire         i_rb_holdoff,
  output logic        o_rb_stb,
  output logic [63:0] o_rb_data,
  // Host streams
  input  wire  [31:0] i_tx_tdata,
  input  wire         i_tx_tlast,
  input  wire         i_tx_tvalid,
  output logic        o_tx_tready,
  output logic [31:0] o_rx_tdata,
  output logic        o_rx_tlast,
  output logic        o_rx_tvalid,
  input  wire         i_rx_tready,
  output logic [63:0] o_resp_tdata,
  output logic        o_resp_tvalid,
  input  wire         i_resp_ready
);

  logic        loopback;
  logic [31:0] test_word;
  logic [31:0] rx_sample;
  logic        rx_strobe;
  logic [63:0] txresp_tdata;
  logic        txresp_valid;
  logic        txresp_taken;
  logic [63:0] rxresp_tdata;
  logic        rxresp_valid;
  logic        rxresp_taken;

  // Readback mux
  always_comb begin
    o_rb_stb  = ~i_rb_holdoff;
    case (i_rb_addr)
      RB_VITA_TIME:    o_rb_data = i_vita_time;
      RB_VITA_LASTPPS: o_rb_data = i_vita_time_lastpps;
      RB_TEST:         o_rb_data = {i_rx, test_word};
      RB_TXRX:         o_rb_data = {o_tx, i_rx};
      RB_RADIO_NUM:    o_rb_data = {32'd0, RADIO_NUM};
      default: begin
        o_rb_stb  = 1'b0;
        o_rb_data = 64'd0;
      end
    endcase
  end

  // Bit 0 routes TX back into RX
  setting_reg #(.MY_ADDR(SR_LOOPBACK), .WIDTH(1)) sr_loopback (
    .i_clk(i_clk), .i_reset(i_reset), .i_set_stb(i_set_stb), .i_set_addr(i_set_addr),
    .i_set_data(i_set_data), .o_out(loopback), .o_changed());

  // Scratch word for bus checks
  setting_reg #(.MY_ADDR(SR_TEST), .WIDTH(32)) sr_test (
    .i_clk(i_clk), .i_reset(i_reset), .i_set_stb(i_set_stb), .i_set_addr(i_set_addr),
    .i_set_data(i_set_data), .o_out(test_word), .o_changed());

  radio_tx_control u_tx_control (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_vita_time(i_vita_time),
    .i_tx_tdata(i_tx_tdata), .i_tx_tlast(i_tx_tlast), .i_tx_tvalid(i_tx_tvalid),
    .o_tx_tready(o_tx_tready), .i_tx_stb(i_tx_stb),
    .o_tx(o_tx), .o_tx_running(o_tx_running),
    .o_resp_tdata(txresp_tdata), .o_resp_valid(txresp_valid), .i_resp_taken(txresp_taken));

  // Digital loopback select
  assign rx_sample = loopback ? o_tx : i_rx;
  assign rx_strobe = loopback ? i_tx_stb : i_rx_stb;

  radio_rx_control u_rx_control (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_vita_time(i_vita_time), .i_sample(rx_sample), .i_strobe(rx_strobe),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast), .o_rx_tvalid(o_rx_tvalid),
    .i_rx_tready(i_rx_tready), .o_rx_running(o_rx_running),
    .o_resp_tdata(rxresp_tdata), .o_resp_valid(rxresp_valid), .i_resp_taken(rxresp_taken));

  // TX and RX responses share one host stream
  radio_resp_mux u_resp_mux (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_tx_tdata(txresp_tdata), .i_tx_valid(txresp_valid), .o_tx_taken(txresp_taken),
    .i_rx_tdata(rxresp_tdata), .i_rx_valid(rxresp_valid), .o_rx_taken(rxresp_taken),
    .o_resp_tdata(o_resp_tdata), .o_resp_tvalid(o_resp_tvalid), .i_resp_ready(i_resp_ready));

endmodule

`default_nettype wire

//--- verif/radio_chk.sv
/*
 * Assertions bound into radio_datapath_core, sampled on the rising clock edge.
 * Stream and readback checks are off while reset is high.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_chk
  import radio_pkg::*;
(
  input wire        i_clk,
  input wire        i_reset,
  input wire [31:0] i_rx_tdata,
  input wire        i_rx_tlast,
  input wire        i_rx_tvalid,
  input wire        i_rx_tready,
  input wire [63:0] i_resp_tdata,
  input wire        i_resp_tvalid,
  input wire        i_resp_ready,
  input wire        i_tx_running,
  input wire        i_rx_running,
  input wire        i_rb_stb,
  input wire        i_rb_holdoff
);

  // Failure count read by the testbench
  int unsigned n_fail = 0;

  // Stalled beats hold their payload
  rx_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_rx_tvalid && !i_rx_tready |=> i_rx_tvalid && $stable(i_rx_tdata) && $stable(i_rx_tlast))
    else begin
      n_fail++;
      $error("RX beat changed while stalled");
    end

  resp_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_resp_tvalid && !i_resp_ready |=> i_resp_tvalid && $stable(i_resp_tdata))
    else begin
      n_fail++;
      $error("Response word changed while stalled");
    end

  idle_after_reset: assert property (@(posedge i_clk)
    i_reset |=> !i_tx_running && !i_rx_running)
    else begin
      n_fail++;
      $error("Controller running right after reset");
    end

  rb_holdoff_ok: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_rb_stb && i_rb_holdoff))
    else begin
      n_fail++;
      $error("Readback strobe during holdoff");
    end

  resp_code_ok: assert property (@(posedge i_clk) disable iff (i_reset)
    i_resp_tvalid |-> i_resp_tdata[63:60] inside {RESP_TX_ACK, RESP_TX_UNDERRUN,
                                                  RESP_RX_OVERFLOW})
    else begin
      n_fail++;
      $error("Undefined response code %h", i_resp_tdata[63:60]);
    end

endmodule

bind radio_datapath_core radio_chk u_chk (
  .i_clk(i_clk), .i_reset(i_reset),
  .i_rx_tdata(o_rx_tdata), .i_rx_tlast(o_rx_tlast), .i_rx_tvalid(o_rx_tvalid),
  .i_rx_tready(i_rx_tready),
  .i_resp_tdata(o_resp_tdata), .i_resp_tvalid(o_resp_tvalid), .i_resp_ready(i_resp_ready),
  .i_tx_running(o_tx_running), .i_rx_running(o_rx_running),
  .i_rb_stb(o_rb_stb), .i_rb_holdoff(i_rb_holdoff)
);

`default_nettype wire

//--- verif/radio_tb.sv
/*
 * Testbench for radio_datapath_core with RADIO_NUM 3.
 * Inputs change on the falling clock edge, and converter strobes come every STB_DIV cycles.
 * Expected RX beats and response codes are queued and checked on each handshake.
 * Assertion failures from the bound checker count toward the final result.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_tb
  import radio_pkg::*;
();

  localparam int CLK_NS      = 8;
  localparam int STB_DIV     = 4;
  localparam int N_TX        = 6;
  localparam int N_UR        = 3;
  localparam int N_RX        = 10;
  localparam int RX_MAXLEN   = 4;
  localparam int N_LB        = 6;
  localparam int DRAIN_LIMIT = 4 * STB_DIV;
  // Test lengths in strobes with slack for register writes and draining
  localparam int TEST_STROBES = 8 + (N_TX + 4) + (N_UR + 4) + (N_RX + 4) + 6 + (N_LB + 6);
  localparam int WATCHDOG_NS  = TEST_STROBES * STB_DIV * CLK_NS * 2;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] rx;
  logic        rx_stb;
  logic        tx_stb;
  logic [63:0] vita_time = 64'd0;
  logic [63:0] lastpps;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [7:0]  rb_addr;
  logic        rb_holdoff;
  logic        rb_stb;
  logic [63:0] rb_data;
  logic [31:0] tx_tdata;
  logic        tx_tlast;
  logic        tx_tvalid;
  logic        tx_tready;
  logic [31:0] rx_tdata;
  logic        rx_tlast;
  logic        rx_tvalid;
  logic        rx_tready;
  logic [63:0] resp_tdata;
  logic        resp_tvalid;
  logic        resp_ready;
  logic [31:0] tx_out;
  logic        tx_running;
  logic        rx_running;

  // Scoreboard queues
  logic [31:0] exp_rx_data[$];
  logic        exp_rx_last[$];
  logic [3:0]  exp_resp[$];

  // Model of the written registers and the sample stream
  logic [31:0] test_word_m;
  logic [31:0] idle_m;
  logic [31:0] rng;
  logic [31:0] samples [0:15];
  int          errors;
  int          errors_at_start;
  int          checks;
  int          tests_pass;
  int          tests_fail;

  radio_datapath_core #(.RADIO_NUM(32'd3)) dut (
    .i_clk(clk), .i_reset(reset), .i_rx(rx), .i_rx_stb(rx_stb), .o_rx_running(rx_running),
    .o_tx(tx_out), .i_tx_stb(tx_stb), .o_tx_running(tx_running),
    .i_vita_time(vita_time), .i_vita_time_lastpps(lastpps),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_addr(rb_addr), .i_rb_holdoff(rb_holdoff), .o_rb_stb(rb_stb), .o_rb_data(rb_data),
    .i_tx_tdata(tx_tdata), .i_tx_tlast(tx_tlast), .i_tx_tvalid(tx_tvalid),
    .o_tx_tready(tx_tready),
    .o_rx_tdata(rx_tdata), .o_rx_tlast(rx_tlast), .o_rx_tvalid(rx_tvalid),
    .i_rx_tready(rx_tready),
    .o_resp_tdata(resp_tdata), .o_resp_tvalid(resp_tvalid), .i_resp_ready(resp_ready));

  always #(CLK_NS / 2) clk = ~clk;

  // Free-running time that changes with the other inputs
  always @(negedge clk) vita_time <= vita_time + 64'd1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Strobe in bit 64 above the data
  // TX is idle whenever readback is checked
  function automatic logic [64:0] rb_expect(input logic [7:0] addr, input logic holdoff);
    case (addr)
      RB_VITA_TIME:    return {~holdoff, vita_time};
      RB_VITA_LASTPPS: return {~holdoff, lastpps};
      RB_TEST:         return {~holdoff, rx, test_word_m};
      RB_TXRX:         return {~holdoff, idle_m, rx};
      RB_RADIO_NUM:    return {~holdoff, 32'd0, 32'd3};
      default:         return 65'd0;
    endcase
  endfunction

  // Beat list of a finite command; tlast every maxlen beats and on the final one
  function automatic void predict_rx(input int count, input int maxlen);
    for (int i = 0; i < count; i++) begin
      exp_rx_data.push_back(samples[i]);
      exp_rx_last.push_back(((i + 1) % maxlen == 0) || (i == count - 1));
    end
  endfunction

  function automatic logic [3:0] resp_for(input logic from_tx, input logic saw_tlast);
    if (!from_tx) begin
      return RESP_RX_OVERFLOW;
    end
    return saw_tlast ? RESP_TX_ACK : RESP_TX_UNDERRUN;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge clk);
    set_stb  = 1'b0;
  endtask

  // One converter strobe followed by the gap up to the next one
  task automatic strobe(input logic use_tx, input logic use_rx, input logic give_beat,
                        input logic [31:0] data, input logic last);
    @(negedge clk);
    tx_stb    = use_tx;
    rx_stb    = use_rx;
    tx_tvalid = give_beat;
    tx_tdata  = data;
    tx_tlast  = last;
    rx        = data;
    // The stream is ready exactly on TX strobes
    @(posedge clk);
    check("o_tx_tready", tx_tready, use_tx);
    @(negedge clk);
    tx_stb    = 1'b0;
    rx_stb    = 1'b0;
    tx_tvalid = 1'b0;
    tx_tlast  = 1'b0;
    repeat (STB_DIV - 2) @(negedge clk);
  endtask

  task automatic wait_rx_running();
    int n;
    n = 0;
    while (!rx_running && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rx_running) begin
      errors++;
      $display("RX command did not start within %0d cycles", DRAIN_LIMIT);
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while ((exp_rx_data.size() != 0 || exp_resp.size() != 0) && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_rx_data.size() != 0 || exp_resp.size() != 0) begin
      errors++;
      $display("%0d RX beats and %0d responses never arrived", exp_rx_data.size(),
               exp_resp.size());
      exp_rx_data.delete();
      exp_rx_last.delete();
      exp_resp.delete();
    end
    if (errors == errors_at_start) begin
      tests_pass++;
      $display("test %s: pass", name);
    end else begin
      tests_fail++;
      $display("test %s: fail with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Compares every RX beat and response word as it is handed over
  always @(posedge clk) begin
    if (!reset && rx_tvalid && rx_tready) begin
      if (exp_rx_data.size() == 0) begin
        errors++;
        $display("RX beat %h arrived at %0t ns with none expected", rx_tdata, $time);
      end else begin
        check("o_rx_tdata", rx_tdata, exp_rx_data.pop_front());
        check("o_rx_tlast", rx_tlast, exp_rx_last.pop_front());
      end
    end
    if (!reset && resp_tvalid && resp_ready) begin
      if (exp_resp.size() == 0) begin
        errors++;
        $display("Response %h arrived at %0t ns with none expected", resp_tdata, $time);
      end else begin
        check("o_resp_tdata[63:60]", resp_tdata[63:60], exp_resp.pop_front());
        check("o_resp_tdata[59:48]", resp_tdata[59:48], 0);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int i;
    logic [64:0] e;
    reset = 1'b1;
    rx = '0;
    rx_stb = 1'b0;
    tx_stb = 1'b0;
    lastpps = 64'h0000_0042_0000_1000;
    set_stb = 1'b0;
    set_addr = '0;
    set_data = '0;
    rb_addr = '0;
    rb_holdoff = 1'b0;
    tx_tdata = '0;
    tx_tlast = 1'b0;
    tx_tvalid = 1'b0;
    rx_tready = 1'b1;
    resp_ready = 1'b1;
    rng = 32'd1;
    errors = 0;
    errors_at_start = 0;
    checks = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Readback of all addresses with address 5 unmapped
    test_word_m = 32'hC0DE_1234;
    idle_m = 32'h0BAD_F00D;
    write_reg(SR_TEST, test_word_m);
    write_reg(SR_CODEC_IDLE, idle_m);
    rx = 32'h5A5A_0001;
    for (i = 0; i < 12; i++) begin
      @(negedge clk);
      rb_addr = 8'(i / 2);
      rb_holdoff = i[0];
      @(posedge clk);
      e = rb_expect(rb_addr, rb_holdoff);
      check("o_rb_stb", rb_stb, e[64]);
      check("o_rb_data", rb_data, e[63:0]);
    end
    @(negedge clk);
    rb_holdoff = 1'b0;
    end_test("readback");

    // Burst ending in tlast and closed by a starved strobe
    for (i = 0; i < N_TX; i++) begin
      rng = xorshift(rng);
      samples[i] = rng;
      strobe(1'b1, 1'b0, 1'b1, samples[i], i == N_TX - 1);
      check("o_tx", tx_out, samples[i]);
      check("o_tx_running", tx_running, 1);
    end
    exp_resp.push_back(resp_for(1'b1, 1'b1));
    strobe(1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    check("o_tx", tx_out, idle_m);
    check("o_tx_running", tx_running, 0);
    end_test("tx burst");

    // Valid withheld before any tlast
    for (i = 0; i < N_UR; i++) begin
      rng = xorshift(rng);
      strobe(1'b1, 1'b0, 1'b1, rng, 1'b0);
    end
    exp_resp.push_back(resp_for(1'b1, 1'b0));
    strobe(1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    check("o_tx_running", tx_running, 0);
    check("o_tx", tx_out, idle_m);
    end_test("tx underrun");

    // Finite command split into packets
    write_reg(SR_RX_MAXLEN, RX_MAXLEN);
    write_reg(SR_RX_CMD, N_RX);
    wait_rx_running();
    for (i = 0; i < N_RX; i++) begin
      rng = xorshift(rng);
      samples[i] = rng;
    end
    predict_rx(N_RX, RX_MAXLEN);
    for (i = 0; i < N_RX; i++) begin
      strobe(1'b0, 1'b1, 1'b0, samples[i], 1'b0);
    end
    check("o_rx_running", rx_running, 0);
    end_test("rx finite");

    // Host stalled so the second strobe overflows
    rx_tready = 1'b0;
    write_reg(SR_RX_CMD, 32'h8000_0000);
    wait_rx_running();
    rng = xorshift(rng);
    samples[0] = rng;
    rng = xorshift(rng);
    samples[1] = rng;
    // First beat of a continuous packet carries no tlast
    exp_rx_data.push_back(samples[0]);
    exp_rx_last.push_back(1'b0);
    exp_resp.push_back(resp_for(1'b0, 1'b0));
    strobe(1'b0, 1'b1, 1'b0, samples[0], 1'b0);
    strobe(1'b0, 1'b1, 1'b0, samples[1], 1'b0);
    check("o_rx_running", rx_running, 0);
    check("o_rx_tvalid", rx_tvalid, 1);
    @(negedge clk);
    rx_tready = 1'b1;
    end_test("rx overflow");

    // RX takes o_tx on each TX strobe and so runs one strobe behind the stream
    write_reg(SR_LOOPBACK, 32'd1);
    for (i = 0; i < N_LB; i++) begin
      rng = xorshift(rng);
      samples[i] = rng;
    end
    predict_rx(N_LB, RX_MAXLEN);
    exp_resp.push_back(resp_for(1'b1, 1'b1));
    strobe(1'b1, 1'b0, 1'b1, samples[0], 1'b0);
    write_reg(SR_RX_CMD, N_LB);
    wait_rx_running();
    for (i = 1; i < N_LB; i++) begin
      strobe(1'b1, 1'b0, 1'b1, samples[i], i == N_LB - 1);
    end
    // Ends the burst while RX takes its final sample
    strobe(1'b1, 1'b0, 1'b0, 32'd0, 1'b0);
    check("o_tx_running", tx_running, 0);
    check("o_rx_running", rx_running, 0);
    end_test("loopback");

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_pass, tests_fail, checks, errors, dut.u_chk.n_fail);
    if (tests_fail == 0 && errors == 0 && dut.u_chk.n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hdl/radio_pkg.sv
hdl/setting_reg.sv
hdl/radio_tx_control.sv
hdl/radio_rx_control.sv
hdl/radio_resp_mux.sv
hdl/radio_datapath_core.sv
verif/radio_chk.sv
verif/radio_tb.sv

//--- Bender.yml
package:
  name: radio_datapath

sources:
  - hdl/radio_pkg.sv
  - hdl/setting_reg.sv
  - hdl/radio_tx_control.sv
  - hdl/radio_rx_control.sv
  - hdl/radio_resp_mux.sv
  - hdl/radio_datapath_core.sv
  - target: test
    files:
      - verif/radio_chk.sv
      - verif/radio_tb.sv
